/* hdl/synth_pkg.sv */
package synth_pkg;

   localparam int num_notes    = 5;
   localparam int num_switches = 8;
   localparam int num_chords   = 16;

   localparam int note_w   = 7;
   localparam int level_w  = 6;
   localparam int sample_w = 8;
   localparam int phase_w  = 10;

   typedef logic [note_w-1:0] note_t;

   localparam logic [level_w-1:0] level_max = 6'd63;
   localparam int pwm_offset = 127; // duty midpoint

   localparam int env_slow_div = 4; // frames per level step
   localparam int env_div_w    = $clog2(env_slow_div);

   // note codes, one semitone apart except C0 to D0
   localparam note_t note_c0  = 7'd57;
   localparam note_t note_d0  = 7'd59;
   localparam note_t note_eb0 = 7'd60;
   localparam note_t note_e0  = 7'd61;
   localparam note_t note_f0  = 7'd62;
   localparam note_t note_gb0 = 7'd63;
   localparam note_t note_g0  = 7'd64;
   localparam note_t note_ab0 = 7'd65;
   localparam note_t note_a0  = 7'd66;
   localparam note_t note_bb0 = 7'd67;
   localparam note_t note_b0  = 7'd68;
   localparam note_t note_c1  = 7'd69;

   // indexed by sw[7:4]
   localparam note_t [0:num_chords-1][0:num_notes-1] chord_table = '{
      '{note_c0,  note_eb0, note_f0,  note_g0,  note_bb0},
      '{note_c0,  note_eb0, note_g0,  note_bb0, note_c1},
      '{note_c0,  note_eb0, note_f0,  note_g0,  note_ab0},
      '{note_d0,  note_e0,  note_gb0, note_g0,  note_a0},
      '{note_c0,  note_d0,  note_eb0, note_f0,  note_ab0},
      '{note_c0,  note_d0,  note_g0,  note_a0,  note_bb0},
      '{note_c0,  note_d0,  note_eb0, note_f0,  note_g0},
      '{note_c0,  note_d0,  note_e0,  note_gb0, note_g0},
      '{note_d0,  note_e0,  note_f0,  note_g0,  note_ab0},
      '{note_c0,  note_eb0, note_f0,  note_g0,  note_a0},
      '{note_eb0, note_f0,  note_g0,  note_ab0, note_c1},
      '{note_c0,  note_e0,  note_g0,  note_b0,  note_c1},
      '{note_c0,  note_d0,  note_e0,  note_g0,  note_a0},
      '{note_d0,  note_eb0, note_g0,  note_ab0, note_bb0},
      '{note_f0,  note_g0,  note_a0,  note_b0,  note_c1},
      '{note_c0,  note_d0,  note_e0,  note_f0,  note_g0}
   };

   typedef enum logic [1:0] {
      wave_square = 2'd0,
      wave_saw    = 2'd1,
      wave_tri    = 2'd2,
      wave_mute   = 2'd3
   } wave_e;

   typedef enum logic [1:0] {
      env_hold        = 2'd0,
      env_pluck       = 2'd1,
      env_swell       = 2'd2,
      env_swell_pluck = 2'd3
   } env_preset_e;

   typedef enum logic [1:0] {
      env_idle,
      env_attack,
      env_decay,
      env_sustain
   } env_state_e;

   // attack/decay indexes per preset, zero means instant
   localparam logic [0:3][3:0] env_attack_idx = '{4'd0, 4'd0, 4'd10, 4'd10};
   localparam logic [0:3][3:0] env_decay_idx  = '{4'd0, 4'd10, 4'd0, 4'd10};
   localparam logic [0:3][level_w-1:0] env_sustain_lvl = '{level_max, 6'd0, level_max, 6'd0};

endpackage

/* hdl/voice_if.sv */
`timescale 1ns/1ns

// selected note and voice settings, plain levels
interface voice_if;

   synth_pkg::note_t       note;
   logic                   note_on;
   synth_pkg::wave_e       wave_sel;
   synth_pkg::env_preset_e env_sel;

   modport source (
      output note,
      output note_on,
      output wave_sel,
      output env_sel
   );

   modport sink (
      input note,
      input note_on,
      input wave_sel,
      input env_sel
   );

endinterface

/* hdl/key_front.sv */
`timescale 1ns/1ns

module key_front (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic [synth_pkg::num_switches-1:0]  sw,
   input  logic [synth_pkg::num_notes-1:0]     note_enn,
   voice_if.source                             voice
);

   logic [synth_pkg::num_switches-1:0] sw_sync [3];
   logic [synth_pkg::num_notes-1:0]    key_sync [3]; // active high after inversion

   logic [synth_pkg::num_notes-1:0]    keys;
   logic [synth_pkg::num_notes-1:0]    key_onehot;
   logic [$clog2(synth_pkg::num_notes)-1:0] key_idx;
   logic [3:0]                         chord_code;

   synth_pkg::note_t [0:synth_pkg::num_notes-1] chord_set;

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         for (int i = 0; i < 3; i++)
         begin
            sw_sync[i]  <= '0;
            key_sync[i] <= '0;
         end
      end
      else
      begin
         sw_sync[0]  <= sw;
         key_sync[0] <= ~note_enn;
         for (int i = 1; i < 3; i++)
         begin
            sw_sync[i]  <= sw_sync[i-1];
            key_sync[i] <= key_sync[i-1];
         end
      end
   end

   assign keys       = key_sync[2];
   assign chord_code = sw_sync[2][synth_pkg::num_switches-1 -: 4];
   assign chord_set  = synth_pkg::chord_table[chord_code];

   // lowest pressed key wins
   assign key_onehot = keys & (~keys + 1'b1);

   always_comb
   begin
      key_idx = '0;
      for (int i = 0; i < synth_pkg::num_notes; i++)
      begin
         if (key_onehot[i])
         begin
            key_idx = ($clog2(synth_pkg::num_notes))'(i);
         end
      end
   end

   assign voice.note     = chord_set[key_idx];
   assign voice.note_on  = |keys;
   assign voice.wave_sel = synth_pkg::wave_e'(sw_sync[2][1:0]);
   assign voice.env_sel  = synth_pkg::env_preset_e'(sw_sync[2][3:2]);

   // at most one key selected, and only when some key is down
   a_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(key_onehot) && ((|key_onehot) == voice.note_on));

endmodule

/* hdl/envelope_gen.sv */
`timescale 1ns/1ns

module envelope_gen (
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            frame,
   voice_if.sink                           voice,
   output logic [synth_pkg::level_w-1:0]   level
);

   synth_pkg::env_state_e              state;
   logic [synth_pkg::env_div_w-1:0]    div_cnt;
   logic                               step;
   logic                               fast_attack;
   logic                               fast_decay;
   logic [synth_pkg::level_w-1:0]      sustain;

   assign step        = (div_cnt == synth_pkg::env_div_w'(synth_pkg::env_slow_div - 1));
   assign fast_attack = (synth_pkg::env_attack_idx[voice.env_sel] == 4'd0);
   assign fast_decay  = (synth_pkg::env_decay_idx[voice.env_sel] == 4'd0);
   assign sustain     = synth_pkg::env_sustain_lvl[voice.env_sel];

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state   <= synth_pkg::env_idle;
         level   <= '0;
         div_cnt <= '0;
      end
      else if (frame)
      begin
         if (!voice.note_on)
         begin
            state   <= synth_pkg::env_idle; // release drops straight to zero
            level   <= '0;
            div_cnt <= '0;
         end
         else
         begin
            div_cnt <= step ? '0 : div_cnt + 1'b1;
            case (state)
               synth_pkg::env_idle:
               begin
                  div_cnt <= '0;
                  if (fast_attack)
                  begin
                     level <= synth_pkg::level_max;
                     state <= synth_pkg::env_decay;
                  end
                  else
                  begin
                     level <= synth_pkg::level_w'(1); // first step right away
                     state <= synth_pkg::env_attack;
                  end
               end
               synth_pkg::env_attack:
               begin
                  if (step)
                  begin
                     if (level >= synth_pkg::level_max - 1'b1)
                     begin
                        level <= synth_pkg::level_max;
                        state <= synth_pkg::env_decay;
                     end
                     else
                     begin
                        level <= level + 1'b1;
                     end
                  end
               end
               synth_pkg::env_decay:
               begin
                  if (fast_decay || level <= sustain)
                  begin
                     level <= sustain;
                     state <= synth_pkg::env_sustain;
                  end
                  else if (step)
                  begin
                     level <= level - 1'b1;
                  end
               end
               default:
               begin
                  state <= synth_pkg::env_sustain; // hold until keys released
               end
            endcase
         end
      end
   end

   a_level_max: assert property (@(posedge clk) disable iff (!rstn)
      level <= synth_pkg::level_max);

endmodule

/* hdl/wave_osc.sv */
`timescale 1ns/1ns

module wave_osc (
   input  logic                                    clk,
   input  logic                                    rstn,
   input  logic                                    frame,
   voice_if.sink                                   voice,
   output logic signed [synth_pkg::sample_w-1:0]   sample
);

   localparam int pw = synth_pkg::phase_w;
   localparam int sw = synth_pkg::sample_w;

   logic [pw-1:0]        phase;
   logic [pw-1:0]        phase_next;
   logic [sw-1:0]        fold;
   logic signed [sw-1:0] shaped;

   assign phase_next = voice.note_on ? phase + pw'(voice.note) : phase;

   always_comb
   begin
      // triangle folds the lower bits back on the second half
      fold = phase_next[pw-1] ? ~phase_next[pw-2 -: sw] : phase_next[pw-2 -: sw];
      case (voice.wave_sel)
         synth_pkg::wave_square:
            shaped = phase_next[pw-1] ? 8'sh80 : 8'sh7f;
         synth_pkg::wave_saw:
            shaped = $signed({~phase_next[pw-1], phase_next[pw-2 -: sw-1]}); // top bits - 128
         synth_pkg::wave_tri:
            shaped = $signed({~fold[sw-1], fold[sw-2:0]});
         default:
            shaped = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         phase  <= '0;
         sample <= '0;
      end
      else if (frame)
      begin
         phase  <= phase_next;
         sample <= shaped;
      end
   end

endmodule

/* hdl/pwm_dac.sv */
`timescale 1ns/1ns

module pwm_dac (
   input  logic                                    clk,
   input  logic                                    rstn,
   input  logic [synth_pkg::level_w-1:0]           level,
   input  logic signed [synth_pkg::sample_w-1:0]   sample,
   output logic                                    frame,
   output logic                                    pwm_out
);

   localparam int sw = synth_pkg::sample_w;
   localparam int lw = synth_pkg::level_w;

   logic [sw-1:0]          frame_cnt;
   logic [sw-1:0]          on_cnt;
   logic signed [sw+lw:0]  prod;
   logic signed [sw+lw:0]  scaled;
   logic [sw-1:0]          duty;

   assign frame = (frame_cnt == '1);

   // sample scaled by envelope, level is a fraction of 64
   assign prod   = sample * $signed({1'b0, level});
   assign scaled = prod >>> lw;
   assign duty   = sw'(scaled + synth_pkg::pwm_offset);

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         frame_cnt <= '0;
      end
      else
      begin
         frame_cnt <= frame_cnt + 1'b1; // wraps every 256
      end
   end

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         on_cnt  <= '0;
         pwm_out <= 1'b0;
      end
      else
      begin
         if (frame)
         begin
            on_cnt <= duty;
         end
         else if (on_cnt != '0)
         begin
            on_cnt <= on_cnt - 1'b1;
         end
         pwm_out <= (on_cnt != '0);
      end
   end

   // low at every frame boundary, so a high run is shorter than 256
   a_pwm_run: assert property (@(posedge clk) disable iff (!rstn)
      frame |-> !pwm_out);

   a_duty_nonzero: assert property (@(posedge clk) disable iff (!rstn)
      frame |-> (duty != '0));

endmodule

/* hdl/synth_top.sv */
`timescale 1ns/1ns

module synth_top (
   input  logic                                clk,
   input  logic                                rstn,
   input  logic [synth_pkg::num_switches-1:0]  sw,
   input  logic [synth_pkg::num_notes-1:0]     note_enn,
   output logic                                pwm_out
);

   logic [synth_pkg::level_w-1:0]          level;
   logic signed [synth_pkg::sample_w-1:0]  sample;
   logic                                   frame;

   voice_if voice ();

   key_front u_key_front (
      .clk      (clk),
      .rstn     (rstn),
      .sw       (sw),
      .note_enn (note_enn),
      .voice    (voice)
   );

   envelope_gen u_envelope_gen (
      .clk   (clk),
      .rstn  (rstn),
      .frame (frame),
      .voice (voice),
      .level (level)
   );

   wave_osc u_wave_osc (
      .clk    (clk),
      .rstn   (rstn),
      .frame  (frame),
      .voice  (voice),
      .sample (sample)
   );

   pwm_dac u_pwm_dac (
      .clk     (clk),
      .rstn    (rstn),
      .level   (level),
      .sample  (sample),
      .frame   (frame),
      .pwm_out (pwm_out)
   );

endmodule

/* dv/synth_checker.sv */
`timescale 1ns/1ns

module synth_checker (
   input  logic        clk,
   input  logic        pwm_out,
   input  logic        start,
   input  logic [95:0] name,
   input  logic [1:0]  kind,
   input  int          window,
   input  int          exp_a,
   input  int          exp_b,
   input  int          exp_c,
   output int          tests_done,
   output int          pass_count,
   output int          fail_count
);

   localparam int frame_len = 256;

   localparam logic [1:0] kind_const  = 2'd0; // every frame equals exp_a
   localparam logic [1:0] kind_pair   = 2'd1; // min exp_a, max exp_b, exp_c values
   localparam logic [1:0] kind_rises  = 2'd2; // 1 -> 252 steps, exp_a give or take one
   localparam logic [1:0] kind_spread = 2'd3;

   int    lo;
   int    hi;
   int    distinct;
   int    rises;
   int    errors;
   bit    seen [0:frame_len];
   string label;

   function automatic string label_text(input logic [95:0] bits);
      string s;
      s = "";
      for (int i = 11; i >= 0; i--)
      begin
         if (bits[8*i +: 8] != 8'h00)
            s = {s, $sformatf("%c", bits[8*i +: 8])};
      end
      return s;
   endfunction

   task automatic flag(input string what, input int expected, input int actual);
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", label, what, expected, actual);
      errors++;
   endtask

   // sampled on falling edges, each window starts at a pwm rise
   task automatic measure();
      logic last;
      int   high;
      int   prev;
      last = 1'b1;
      while (!(pwm_out && !last))
      begin
         last = pwm_out;
         @(negedge clk);
      end
      lo       = frame_len;
      hi       = 0;
      distinct = 0;
      rises    = 0;
      prev     = -1;
      foreach (seen[v])
         seen[v] = 1'b0;
      for (int f = 0; f < window; f++)
      begin
         high = 0;
         repeat (frame_len)
         begin
            if (pwm_out)
               high++;
            @(negedge clk);
         end
         if (high < lo)
            lo = high;
         if (high > hi)
            hi = high;
         if (!seen[high])
            distinct++;
         seen[high] = 1'b1;
         if (prev == 1 && high == 252) // phase wrap on a full scale square
            rises++;
         prev = high;
      end
   endtask

   task automatic judge();
      errors = 0;
      label  = label_text(name);
      case (kind)
         kind_const:
         begin
            if (lo != exp_a)
               flag("min high time", exp_a, lo);
            if (hi != exp_a)
               flag("max high time", exp_a, hi);
         end
         kind_pair:
         begin
            if (lo != exp_a)
               flag("min high time", exp_a, lo);
            if (hi != exp_b)
               flag("max high time", exp_b, hi);
            if (distinct != exp_c)
               flag("distinct high times", exp_c, distinct);
         end
         kind_rises:
         begin
            if (rises < exp_a - 1 || rises > exp_a + 1)
               flag("1 to 252 steps", exp_a, rises);
         end
         kind_spread:
         begin
            if (lo > exp_a)
               flag("min high time at most", exp_a, lo);
            if (hi < exp_b)
               flag("max high time at least", exp_b, hi);
            if (distinct < exp_c)
               flag("distinct high times at least", exp_c, distinct);
         end
      endcase
      if (errors == 0)
         pass_count++;
      else
         fail_count++;
      $display("%s %s: %0d frames, min %0d max %0d distinct %0d steps %0d",
               (errors == 0) ? "pass" : "fail", label, window, lo, hi, distinct, rises);
   endtask

   initial
   begin
      tests_done = 0;
      pass_count = 0;
      fail_count = 0;
      forever
      begin
         @(negedge clk);
         if (start)
         begin
            measure();
            judge();
            tests_done++;
         end
      end
   end

endmodule

/* dv/synth_tb.sv */
`timescale 1ns/1ns

module synth_tb;

   localparam int frame_len      = 256;
   localparam int half_period    = 20;
   localparam int drive_delay    = 5;
   localparam int reset_cycles   = 8;
   localparam int release_frames = 2; // keys up between tests so the envelope restarts
   localparam int num_tests      = 9;

   localparam logic [1:0] kind_const  = 2'd0;
   localparam logic [1:0] kind_pair   = 2'd1;
   localparam logic [1:0] kind_rises  = 2'd2;
   localparam logic [1:0] kind_spread = 2'd3;

   typedef struct packed {
      logic [95:0] name;
      logic [7:0]  sw;
      logic [4:0]  note_enn;
      int          settle;
      int          window;
      logic [1:0]  kind;
      int          exp_a;
      int          exp_b;
      int          exp_c;
   } test_t;

   // sw is {chord code, env preset, wave}, note_enn active low
   // full scale square: 127 + (127*63)>>6 = 252 and 127 + (-128*63)>>6 = 1
   // rises per 256 frames is note code / 4, odd note walks every phase in 1024 frames
   localparam test_t tests [0:num_tests-1] = '{
      '{"idle",         8'h00, 5'h1f,   2,    8, kind_const,  127,   0, 0},
      '{"mute",         8'h03, 5'h1e,   3,    8, kind_const,  127,   0, 0},
      '{"square_hold",  8'h00, 5'h1e,   3,   32, kind_pair,     1, 252, 2},
      '{"pluck_decay",  8'h04, 5'h1e, 260,    8, kind_const,  127,   0, 0},
      '{"chord0_key0",  8'h00, 5'h1e,   3,  256, kind_rises,   14,   0, 0}, // C0 = 57
      '{"chord14_key3", 8'he0, 5'h07,   3,  256, kind_rises,   17,   0, 0}, // B0 = 68
      '{"chord14_key0", 8'he0, 5'h0e,   3,  256, kind_rises,   15,   0, 0}, // F0 = 62 over C1
      '{"saw",          8'h01, 5'h1e,   3, 1024, kind_spread,   3, 250, 9},
      '{"triangle",     8'h02, 5'h1e,   3, 1024, kind_spread,   3, 250, 9}
   };

   logic       clk;
   logic       rstn;
   logic [7:0] sw;
   logic [4:0] note_enn;
   logic       pwm_out;
   logic       start;
   test_t      cur;
   int         tests_done;
   int         pass_count;
   int         fail_count;
   int         cycle_count;
   int         cycle_limit;

   synth_top uut (
      .clk      (clk),
      .rstn     (rstn),
      .sw       (sw),
      .note_enn (note_enn),
      .pwm_out  (pwm_out)
   );

   synth_checker chk (
      .clk        (clk),
      .pwm_out    (pwm_out),
      .start      (start),
      .name       (cur.name),
      .kind       (cur.kind),
      .window     (cur.window),
      .exp_a      (cur.exp_a),
      .exp_b      (cur.exp_b),
      .exp_c      (cur.exp_c),
      .tests_done (tests_done),
      .pass_count (pass_count),
      .fail_count (fail_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   function automatic int timeout_cycles();
      int frames;
      frames = 0;
      for (int i = 0; i < num_tests; i++)
         frames += release_frames + tests[i].settle + tests[i].window;
      return reset_cycles + frames * frame_len * 12 / 10; // 20% margin
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #drive_delay;
   endtask

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("timeout: tests did not finish within %0d cycles", cycle_limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial
   begin
      rstn        = 1'b0;
      sw          = '0;
      note_enn    = '1;
      start       = 1'b0;
      cur         = '0;
      cycle_count = 0;
      cycle_limit = timeout_cycles();
      wait_cycles(reset_cycles);
      rstn = 1'b1;
      for (int i = 0; i < num_tests; i++)
      begin
         note_enn = '1;
         wait_cycles(release_frames * frame_len);
         sw       = tests[i].sw;
         note_enn = tests[i].note_enn;
         wait_cycles(tests[i].settle * frame_len);
         cur   = tests[i];
         start = 1'b1; // one cycle pulse
         wait_cycles(1);
         start = 1'b0;
         wait (tests_done == i + 1);
         wait_cycles(1);
      end
      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* project.f */
hdl/synth_pkg.sv
hdl/voice_if.sv
hdl/key_front.sv
hdl/envelope_gen.sv
hdl/wave_osc.sv
hdl/pwm_dac.sv
hdl/synth_top.sv
dv/synth_checker.sv
dv/synth_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build synth_tb with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module synth_tb -f project.f -Mdir obj_dir
	./obj_dir/Vsynth_tb | awk '{ print } /^SIMULATION PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
